/* sources.f */
reg_pkg.sv
apb_frontend.sv
ctrl_regs.sv
status_regs.sv
reg_block_top.sv
tb_reg_block.sv

/* Bender.yml */
package:
  name: reg_block

sources:
  - reg_pkg.sv
  - apb_frontend.sv
  - ctrl_regs.sv
  - status_regs.sv
  - reg_block_top.sv
  - target: test
    files:
      - tb_reg_block.sv

/* tb_reg_block.sv */
`default_nettype none

module tb_reg_block;

  localparam int unsigned MAX_CYCLES = 2000; // about 60 transfers of 4 cycles, plus waits.

  logic                            clk;
  logic                            i_arst_n;
  logic                            i_psel;
  logic                            i_penable;
  logic [reg_pkg::ADDR_W-1:0]      i_paddr;
  logic                            i_pwrite;
  logic [reg_pkg::STRB_W-1:0]      i_pstrb;
  logic [reg_pkg::DATA_W-1:0]      i_pwdata;
  logic                            o_pready;
  logic [reg_pkg::DATA_W-1:0]      o_prdata;
  logic                            o_pslverr;
  logic [reg_pkg::STATUS_W-1:0]    i_hw_status;
  logic [reg_pkg::EVENT_W-1:0]     i_event_set;
  logic [reg_pkg::MODE_W-1:0]      o_ctrl_mode;
  logic                            o_ctrl_enable;
  logic [reg_pkg::LEVEL_W-1:0]     o_ctrl_level;
  logic [reg_pkg::TRIG_W-1:0]      o_cmd_trigger;
  logic [reg_pkg::EVENT_W-1:0]     o_event;
  logic                            o_irq;
  logic [reg_pkg::COUNT_W-1:0]     o_count;

  int unsigned errors;
  int unsigned tests_passed;
  int unsigned tests_failed;
  int unsigned cycles;
  int unsigned seed_init;
  logic [31:0] rd;
  logic        err;
  logic [3:0]  trig_at_ready;          // o_cmd_trigger seen in the pready cycle.

  // reference model of the register state.
  logic [3:0]  m_mode;
  logic        m_enable;
  logic [1:0]  m_level;
  logic [3:0]  m_event;
  logic [3:0]  m_mask;

  reg_block_top u_reg_block_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB master.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [reg_pkg::ADDR_W-1:0] reg_addr(input logic [15:0] ofs);
    return reg_pkg::BASE_ADDR + ofs;
  endfunction

  task automatic apb_xfer(input logic [15:0] addr, input logic wr, input logic [31:0] wdata,
                          input logic [3:0] strb, output logic [31:0] rdata,
                          output logic slverr);
    int waited;
    @(posedge clk);
    #1;
    i_psel    = 1'b1;                  // setup cycle.
    i_penable = 1'b0;
    i_paddr   = addr;
    i_pwrite  = wr;
    i_pwdata  = wdata;
    i_pstrb   = strb;
    @(posedge clk);
    #1;
    i_penable = 1'b1;
    waited    = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!o_pready && waited < 4);
    if (!o_pready || waited != 1) begin
      $display("APB transfer to %h: pready did not arrive on the third cycle", addr);
      errors++;
    end
    rdata         = o_prdata;
    slverr        = o_pslverr;
    trig_at_ready = o_cmd_trigger;
    @(posedge clk);                    // request held through the pready cycle.
    #1;
    i_psel    = 1'b0;
    i_penable = 1'b0;
  endtask

  task automatic apb_write(input logic [15:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb, output logic [31:0] rdata,
                           output logic slverr);
    apb_xfer(addr, 1'b1, wdata, strb, rdata, slverr);
  endtask

  task automatic apb_read(input logic [15:0] addr, output logic [31:0] rdata,
                          output logic slverr);
    apb_xfer(addr, 1'b0, '0, '0, rdata, slverr);
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAILED %s: expected 0x%08h, actual 0x%08h", test, exp, act);
    errors++;
  endtask

  task automatic finish_test(input string test, input int unsigned errs_before);
    if (errors == errs_before) begin
      $display("test %s: passed", test);
      tests_passed++;
    end else begin
      $display("test %s: %0d check(s) failed", test, errors - errs_before);
      tests_failed++;
    end
  endtask

  // hold i_event_set for a number of cycles, then drop it.
  task automatic drive_events(input logic [3:0] pattern, input int unsigned n);
    i_event_set = pattern;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
    i_event_set = '0;
    m_event     = m_event | pattern;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_reset();
    int unsigned errs_before;
    errs_before = errors;
    apb_read(reg_addr(reg_pkg::OFS_CTRL), rd, err);
    if (rd !== 32'h0000_0200) report_mismatch("reset CTRL", 32'h0000_0200, rd);
    apb_read(reg_addr(reg_pkg::OFS_EVENT), rd, err);
    if (rd !== 32'h0) report_mismatch("reset EVENT", 32'h0, rd);
    apb_read(reg_addr(reg_pkg::OFS_IRQ_MASK), rd, err);
    if (rd !== 32'h0) report_mismatch("reset IRQ_MASK", 32'h0, rd);
    apb_read(reg_addr(reg_pkg::OFS_COUNT), rd, err);
    if (rd !== 32'h0) report_mismatch("reset COUNT", 32'h0, rd);
    if (o_irq !== 1'b0) report_mismatch("reset o_irq", 32'h0, o_irq);
    if (o_cmd_trigger !== 4'h0) report_mismatch("reset o_cmd_trigger", 32'h0, o_cmd_trigger);
    finish_test("reset values", errs_before);
  endtask

  task automatic test_ctrl_rw();
    int unsigned errs_before;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] exp;
    errs_before = errors;
    repeat (8) begin
      data = $urandom;
      strb = 4'($urandom);
      apb_write(reg_addr(reg_pkg::OFS_CTRL), data, strb, rd, err);
      if (strb[0]) begin
        m_mode   = data[3:0];
        m_enable = data[4];
      end
      if (strb[1]) begin
        m_level = data[9:8];
      end
      exp = {22'd0, m_level, 3'd0, m_enable, m_mode};
      apb_read(reg_addr(reg_pkg::OFS_CTRL), rd, err);
      if (rd !== exp) report_mismatch("ctrl read-back", exp, rd);
      if (err !== 1'b0) report_mismatch("ctrl pslverr", 32'h0, err);
      if (o_ctrl_mode !== m_mode) report_mismatch("ctrl o_ctrl_mode", m_mode, o_ctrl_mode);
      if (o_ctrl_enable !== m_enable) begin
        report_mismatch("ctrl o_ctrl_enable", m_enable, o_ctrl_enable);
      end
      if (o_ctrl_level !== m_level) report_mismatch("ctrl o_ctrl_level", m_level, o_ctrl_level);
    end
    finish_test("ctrl read-write", errs_before);
  endtask

  task automatic test_trigger();
    int unsigned errs_before;
    logic [31:0] data;
    errs_before = errors;
    repeat (4) begin
      data = $urandom;
      apb_write(reg_addr(reg_pkg::OFS_CMD), data, 4'h1, rd, err);
      if (trig_at_ready !== data[3:0]) report_mismatch("trigger pulse", data[3:0], trig_at_ready);
      if (o_cmd_trigger !== 4'h0) report_mismatch("trigger clear", 32'h0, o_cmd_trigger);
    end
    apb_read(reg_addr(reg_pkg::OFS_CMD), rd, err);
    if (rd !== 32'h0) report_mismatch("CMD read", 32'h0, rd);
    finish_test("trigger pulses", errs_before);
  endtask

  task automatic test_events_irq();
    int unsigned errs_before;
    logic [3:0]  clr;
    errs_before = errors;
    drive_events(4'($urandom_range(15, 1)), 1);
    if (o_event !== m_event) report_mismatch("event set", m_event, o_event);
    m_mask = 4'($urandom_range(15, 1));
    apb_write(reg_addr(reg_pkg::OFS_IRQ_MASK), {28'd0, m_mask}, 4'hF, rd, err);
    if (o_irq !== |(m_event & m_mask)) report_mismatch("irq masked", |(m_event & m_mask), o_irq);
    apb_read(reg_addr(reg_pkg::OFS_IRQ_MASK), rd, err);
    if (rd !== {28'd0, m_mask}) report_mismatch("IRQ_MASK read", {28'd0, m_mask}, rd);
    clr = 4'($urandom);
    apb_write(reg_addr(reg_pkg::OFS_EVENT), {28'd0, clr}, 4'h1, rd, err);
    m_event = m_event & ~clr;
    if (o_event !== m_event) report_mismatch("event w1c", m_event, o_event);
    if (o_irq !== |(m_event & m_mask)) begin
      report_mismatch("irq after w1c", |(m_event & m_mask), o_irq);
    end
    apb_write(reg_addr(reg_pkg::OFS_EVENT), 32'hF, 4'h1, rd, err);
    m_event = '0;
    if (o_event !== 4'h0) report_mismatch("event clear all", 32'h0, o_event);
    if (o_irq !== 1'b0) report_mismatch("irq cleared", 32'h0, o_irq);
    finish_test("events and interrupt", errs_before);
  endtask

  task automatic test_status_count();
    int unsigned errs_before;
    int unsigned k;
    errs_before = errors;
    i_hw_status = 8'($urandom);
    apb_read(reg_addr(reg_pkg::OFS_STATUS), rd, err);
    if (rd !== {24'd0, i_hw_status}) report_mismatch("STATUS read", {24'd0, i_hw_status}, rd);
    apb_write(reg_addr(reg_pkg::OFS_STATUS), $urandom, 4'hF, rd, err);
    if (err !== 1'b0) report_mismatch("STATUS write pslverr", 32'h0, err);
    apb_read(reg_addr(reg_pkg::OFS_STATUS), rd, err);
    if (rd !== {24'd0, i_hw_status}) begin
      report_mismatch("STATUS after write", {24'd0, i_hw_status}, rd);
    end
    apb_read(reg_addr(reg_pkg::OFS_COUNT), rd, err); // start the count from zero.
    k = $urandom_range(40, 5);
    drive_events(4'($urandom_range(15, 1)), k);
    if (o_count !== 8'(k)) report_mismatch("o_count after events", k, o_count);
    apb_read(reg_addr(reg_pkg::OFS_COUNT), rd, err);
    if (rd !== k) report_mismatch("COUNT after events", k, rd);
    if (o_count !== 8'h0) report_mismatch("o_count after read", 32'h0, o_count);
    apb_read(reg_addr(reg_pkg::OFS_COUNT), rd, err);
    if (rd !== 32'h0) report_mismatch("COUNT cleared on read", 32'h0, rd);
    finish_test("status and counter", errs_before);
  endtask

  task automatic test_unmapped();
    int unsigned                errs_before;
    logic [reg_pkg::ADDR_W-1:0] bad_addr [3];
    errs_before = errors;
    bad_addr[0] = reg_addr(16'h0018);
    bad_addr[1] = reg_addr(16'h0001); // unaligned.
    bad_addr[2] = 16'h2000;           // outside the block.
    foreach (bad_addr[i]) begin
      apb_read(bad_addr[i], rd, err);
      if (rd !== 32'hDEAD_BEAF) report_mismatch("unmapped rdata", 32'hDEAD_BEAF, rd);
      if (err !== 1'b1) report_mismatch("unmapped read pslverr", 32'h1, err);
      apb_write(bad_addr[i], $urandom, 4'hF, rd, err);
      if (err !== 1'b1) report_mismatch("unmapped write pslverr", 32'h1, err);
    end
    apb_read(reg_addr(reg_pkg::OFS_CTRL), rd, err);
    if (rd !== {22'd0, m_level, 3'd0, m_enable, m_mode}) begin
      report_mismatch("CTRL after unmapped", {22'd0, m_level, 3'd0, m_enable, m_mode}, rd);
    end
    apb_read(reg_addr(reg_pkg::OFS_IRQ_MASK), rd, err);
    if (rd !== {28'd0, m_mask}) report_mismatch("IRQ_MASK after unmapped", {28'd0, m_mask}, rd);
    apb_read(reg_addr(reg_pkg::OFS_EVENT), rd, err);
    if (rd !== {28'd0, m_event}) report_mismatch("EVENT after unmapped", {28'd0, m_event}, rd);
    finish_test("unmapped access", errs_before);
  endtask

  initial begin
    seed_init   = $urandom(32'he95a998d);
    errors      = 0;
    cycles      = 0;
    i_arst_n    = 1'b0;
    i_psel      = 1'b0;
    i_penable   = 1'b0;
    i_paddr     = '0;
    i_pwrite    = 1'b0;
    i_pstrb     = '0;
    i_pwdata    = '0;
    i_hw_status = '0;
    i_event_set = '0;
    m_mode      = '0;
    m_enable    = 1'b0;
    m_level     = 2'b10;
    m_event     = '0;
    m_mask      = '0;
    repeat (8) @(posedge clk);
    #1;
    i_arst_n = 1'b1;

    test_reset();
    test_ctrl_rw();
    test_trigger();
    test_events_irq();
    test_status_count();
    test_unmapped();

    $display("tests passed %0d, tests failed %0d, failed checks %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* reg_block_top.sv */
`default_nettype none

module reg_block_top (
  input  wire                              clk,
  input  wire                              i_arst_n,
  // APB slave.
  input  wire                              i_psel,
  input  wire                              i_penable,
  input  wire  [reg_pkg::ADDR_W-1:0]       i_paddr,
  input  wire                              i_pwrite,
  input  wire  [reg_pkg::STRB_W-1:0]       i_pstrb,
  input  wire  [reg_pkg::DATA_W-1:0]       i_pwdata,
  output logic                             o_pready,
  output logic [reg_pkg::DATA_W-1:0]       o_prdata,
  output logic                             o_pslverr,
  // hardware side.
  input  wire  [reg_pkg::STATUS_W-1:0]     i_hw_status,
  input  wire  [reg_pkg::EVENT_W-1:0]      i_event_set,
  output logic [reg_pkg::MODE_W-1:0]       o_ctrl_mode,
  output logic                             o_ctrl_enable,
  output logic [reg_pkg::LEVEL_W-1:0]      o_ctrl_level,
  output logic [reg_pkg::TRIG_W-1:0]       o_cmd_trigger,
  output logic [reg_pkg::EVENT_W-1:0]      o_event,
  output logic                             o_irq,
  output logic [reg_pkg::COUNT_W-1:0]      o_count
);

  logic                       wr_valid;
  logic                       rd_valid;
  reg_pkg::reg_index_e        reg_index;
  logic [reg_pkg::DATA_W-1:0] wdata;
  logic [reg_pkg::STRB_W-1:0] wstrb;
  logic [reg_pkg::DATA_W-1:0] ctrl_rdata;
  logic [reg_pkg::DATA_W-1:0] status_rdata;

  apb_frontend u_apb_frontend (
    .clk            (clk          ),
    .i_arst_n       (i_arst_n     ),
    .i_psel         (i_psel       ),
    .i_penable      (i_penable    ),
    .i_paddr        (i_paddr      ),
    .i_pwrite       (i_pwrite     ),
    .i_pwdata       (i_pwdata     ),
    .i_pstrb        (i_pstrb      ),
    .i_ctrl_rdata   (ctrl_rdata   ),
    .i_status_rdata (status_rdata ),
    .o_pready       (o_pready     ),
    .o_prdata       (o_prdata     ),
    .o_pslverr      (o_pslverr    ),
    .o_wr_valid     (wr_valid     ),
    .o_rd_valid     (rd_valid     ),
    .o_reg_index    (reg_index    ),
    .o_wdata        (wdata        ),
    .o_wstrb        (wstrb        )
  );

  ctrl_regs u_ctrl_regs (
    .clk           (clk           ),
    .i_arst_n      (i_arst_n      ),
    .i_wr_valid    (wr_valid      ),
    .i_rd_valid    (rd_valid      ),
    .i_reg_index   (reg_index     ),
    .i_wdata       (wdata         ),
    .i_wstrb       (wstrb         ),
    .o_rdata       (ctrl_rdata    ),
    .o_ctrl_mode   (o_ctrl_mode   ),
    .o_ctrl_enable (o_ctrl_enable ),
    .o_ctrl_level  (o_ctrl_level  ),
    .o_cmd_trigger (o_cmd_trigger )
  );

  status_regs u_status_regs (
    .clk         (clk          ),
    .i_arst_n    (i_arst_n     ),
    .i_wr_valid  (wr_valid     ),
    .i_rd_valid  (rd_valid     ),
    .i_reg_index (reg_index    ),
    .i_wdata     (wdata        ),
    .i_wstrb     (wstrb        ),
    .i_hw_status (i_hw_status  ),
    .i_event_set (i_event_set  ),
    .o_rdata     (status_rdata ),
    .o_event     (o_event      ),
    .o_irq       (o_irq        ),
    .o_count     (o_count      )
  );

endmodule

`default_nettype wire

/* status_regs.sv */
`default_nettype none

module status_regs (
  input  wire                              clk,
  input  wire                              i_arst_n,
  input  wire                              i_wr_valid,
  input  wire                              i_rd_valid,
  input  wire  reg_pkg::reg_index_e        i_reg_index,
  input  wire  [reg_pkg::DATA_W-1:0]       i_wdata,
  input  wire  [reg_pkg::STRB_W-1:0]       i_wstrb,
  input  wire  [reg_pkg::STATUS_W-1:0]     i_hw_status,
  input  wire  [reg_pkg::EVENT_W-1:0]      i_event_set,
  output logic [reg_pkg::DATA_W-1:0]       o_rdata,
  output logic [reg_pkg::EVENT_W-1:0]      o_event,
  output logic                             o_irq,
  output logic [reg_pkg::COUNT_W-1:0]      o_count
);

  logic [reg_pkg::EVENT_W-1:0] event_clr;
  logic [reg_pkg::EVENT_W-1:0] irq_mask_q;
  logic                        mask_wr;
  logic                        count_clr;
  logic                        count_inc;
  logic [reg_pkg::DATA_W-1:0]  rd_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // events and interrupt.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign event_clr = (i_wr_valid && (i_reg_index == reg_pkg::IDX_EVENT) && i_wstrb[0]) ?
                     i_wdata[reg_pkg::EVENT_W-1:0] : '0;
  assign mask_wr   = i_wr_valid && (i_reg_index == reg_pkg::IDX_IRQ_MASK) && i_wstrb[0];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_event    <= '0;
      irq_mask_q <= '0;
      o_irq      <= 1'b0;
    end else begin
      o_event <= (o_event & ~event_clr) | i_event_set; // set beats clear.
      if (mask_wr) begin
        irq_mask_q <= i_wdata[reg_pkg::EVENT_W-1:0];
      end
      o_irq <= |(o_event & irq_mask_q);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // event counter, saturating, cleared on read.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign count_clr = i_rd_valid && (i_reg_index == reg_pkg::IDX_COUNT);
  assign count_inc = |i_event_set;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_count <= '0;
    end else if (count_clr) begin
      // an increment in the read cycle is kept.
      o_count <= count_inc ? reg_pkg::COUNT_W'(1) : '0;
    end else if (count_inc && (o_count != '1)) begin
      o_count <= o_count + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read path. STATUS ignores writes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rd_word = '0;
    case (i_reg_index)
      reg_pkg::IDX_STATUS:   rd_word[reg_pkg::STATUS_W-1:0] = i_hw_status;
      reg_pkg::IDX_EVENT:    rd_word[reg_pkg::EVENT_W-1:0]  = o_event;
      reg_pkg::IDX_IRQ_MASK: rd_word[reg_pkg::EVENT_W-1:0]  = irq_mask_q;
      reg_pkg::IDX_COUNT:    rd_word[reg_pkg::COUNT_W-1:0]  = o_count;
      default:               rd_word = '0;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rdata <= '0;
    end else begin
      o_rdata <= i_rd_valid ? rd_word : '0;
    end
  end

  a_one_strobe : assert property (@(posedge clk) disable iff (!i_arst_n)
    !(i_wr_valid && i_rd_valid));

endmodule

`default_nettype wire

/* ctrl_regs.sv */
`default_nettype none

module ctrl_regs (
  input  wire                              clk,
  input  wire                              i_arst_n,
  input  wire                              i_wr_valid,
  input  wire                              i_rd_valid,
  input  wire  reg_pkg::reg_index_e        i_reg_index,
  input  wire  [reg_pkg::DATA_W-1:0]       i_wdata,
  input  wire  [reg_pkg::STRB_W-1:0]       i_wstrb,
  output logic [reg_pkg::DATA_W-1:0]       o_rdata,
  output logic [reg_pkg::MODE_W-1:0]       o_ctrl_mode,
  output logic                             o_ctrl_enable,
  output logic [reg_pkg::LEVEL_W-1:0]      o_ctrl_level,
  output logic [reg_pkg::TRIG_W-1:0]       o_cmd_trigger
);

  logic                       ctrl_wr;
  logic                       cmd_wr;
  logic [reg_pkg::DATA_W-1:0] rd_word;

  assign ctrl_wr = i_wr_valid && (i_reg_index == reg_pkg::IDX_CTRL);
  assign cmd_wr  = i_wr_valid && (i_reg_index == reg_pkg::IDX_CMD) && i_wstrb[0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // CTRL fields.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ctrl_mode   <= '0;
      o_ctrl_enable <= 1'b0;
      o_ctrl_level  <= reg_pkg::LEVEL_RESET;
    end else if (ctrl_wr) begin
      if (i_wstrb[0]) begin
        o_ctrl_mode   <= i_wdata[reg_pkg::MODE_W-1:0];
        o_ctrl_enable <= i_wdata[reg_pkg::MODE_W]; // bit 4.
      end
      if (i_wstrb[1]) begin
        o_ctrl_level <= i_wdata[8 +: reg_pkg::LEVEL_W];
      end
    end
  end

  // trigger is high only in the cycle after the write.
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_cmd_trigger <= '0;
    end else if (cmd_wr) begin
      o_cmd_trigger <= i_wdata[reg_pkg::TRIG_W-1:0];
    end else begin
      o_cmd_trigger <= '0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read path.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rd_word = '0; // CMD and foreign indices read zero.
    if (i_reg_index == reg_pkg::IDX_CTRL) begin
      rd_word[reg_pkg::MODE_W-1:0]   = o_ctrl_mode;
      rd_word[reg_pkg::MODE_W]       = o_ctrl_enable;
      rd_word[8 +: reg_pkg::LEVEL_W] = o_ctrl_level;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rdata <= '0;
    end else begin
      o_rdata <= i_rd_valid ? rd_word : '0;
    end
  end

  a_trigger_pulse : assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_cmd_trigger != '0) |=> (o_cmd_trigger == '0));

endmodule

`default_nettype wire

/* apb_frontend.sv */
`default_nettype none

module apb_frontend (
  input  wire                             clk,
  input  wire                             i_arst_n,
  input  wire                             i_psel,
  input  wire                             i_penable,
  input  wire  [reg_pkg::ADDR_W-1:0]      i_paddr,
  input  wire                             i_pwrite,
  input  wire  [reg_pkg::DATA_W-1:0]      i_pwdata,
  input  wire  [reg_pkg::STRB_W-1:0]      i_pstrb,
  input  wire  [reg_pkg::DATA_W-1:0]      i_ctrl_rdata,
  input  wire  [reg_pkg::DATA_W-1:0]      i_status_rdata,
  output logic                            o_pready,
  output logic [reg_pkg::DATA_W-1:0]      o_prdata,
  output logic                            o_pslverr,
  output logic                            o_wr_valid,
  output logic                            o_rd_valid,
  output reg_pkg::reg_index_e             o_reg_index,
  output logic [reg_pkg::DATA_W-1:0]      o_wdata,
  output logic [reg_pkg::STRB_W-1:0]      o_wstrb
);

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESPOND
  } state_e;

  state_e                     state_q;
  state_e                     state_d;
  logic                       access;
  logic                       mapped;
  logic                       err_q;
  logic [reg_pkg::ADDR_W-1:0] ofs;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address decode.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign ofs = i_paddr - reg_pkg::BASE_ADDR; // below base wraps high, never matches.

  // unaligned and out-of-block addresses miss every offset.
  always_comb begin
    case (ofs)
      reg_pkg::OFS_CTRL:     o_reg_index = reg_pkg::IDX_CTRL;
      reg_pkg::OFS_CMD:      o_reg_index = reg_pkg::IDX_CMD;
      reg_pkg::OFS_STATUS:   o_reg_index = reg_pkg::IDX_STATUS;
      reg_pkg::OFS_EVENT:    o_reg_index = reg_pkg::IDX_EVENT;
      reg_pkg::OFS_IRQ_MASK: o_reg_index = reg_pkg::IDX_IRQ_MASK;
      reg_pkg::OFS_COUNT:    o_reg_index = reg_pkg::IDX_COUNT;
      default:               o_reg_index = reg_pkg::IDX_NONE;
    endcase
  end

  assign mapped = (o_reg_index != reg_pkg::IDX_NONE);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // protocol FSM, one fixed wait state.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (i_psel && !i_penable) begin
          state_d = ACCESS;
        end
      end
      ACCESS: begin
        if (i_psel && i_penable) begin
          state_d = RESPOND;
        end
      end
      default: state_d = IDLE; // respond lasts one cycle.
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (access) begin
        err_q <= !mapped;
      end
    end
  end

  assign access     = (state_q == ACCESS) && i_psel && i_penable;
  assign o_wr_valid = access && i_pwrite && mapped;
  assign o_rd_valid = access && !i_pwrite && mapped;
  assign o_wdata    = i_pwdata;
  assign o_wstrb    = i_pstrb;

  // response; banks hold zero unless they were read.
  assign o_pready  = (state_q == RESPOND);
  assign o_pslverr = o_pready && err_q;
  assign o_prdata  = !o_pready ? '0 :
                     err_q     ? reg_pkg::DEFAULT_RDATA :
                                 (i_ctrl_rdata | i_status_rdata);

  a_req_stable : assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_psel && i_penable && !o_pready) |=> (i_psel && i_penable && $stable(i_paddr) &&
      $stable(i_pwrite) && $stable(i_pwdata) && $stable(i_pstrb)));

  a_pready_single : assert property (@(posedge clk) disable iff (!i_arst_n)
    o_pready |=> !o_pready);

endmodule

`default_nettype wire

/* reg_pkg.sv */
`default_nettype none

package reg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus geometry.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  localparam logic [ADDR_W-1:0] BASE_ADDR     = 16'h1000;
  localparam logic [DATA_W-1:0] DEFAULT_RDATA = 32'hDEAD_BEAF; // unmapped read.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register map, offsets from BASE_ADDR.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [ADDR_W-1:0] OFS_CTRL     = 16'h0000;
  localparam logic [ADDR_W-1:0] OFS_CMD      = 16'h0004;
  localparam logic [ADDR_W-1:0] OFS_STATUS   = 16'h0008;
  localparam logic [ADDR_W-1:0] OFS_EVENT    = 16'h000C;
  localparam logic [ADDR_W-1:0] OFS_IRQ_MASK = 16'h0010;
  localparam logic [ADDR_W-1:0] OFS_COUNT    = 16'h0014;

  // field widths.
  localparam int unsigned MODE_W   = 4;
  localparam int unsigned LEVEL_W  = 2;
  localparam int unsigned TRIG_W   = 4;
  localparam int unsigned STATUS_W = 8;
  localparam int unsigned EVENT_W  = 4;
  localparam int unsigned COUNT_W  = 8;

  localparam logic [LEVEL_W-1:0] LEVEL_RESET = 2'b10;

  // decoded register, IDX_NONE for anything unmapped.
  typedef enum logic [2:0] {
    IDX_CTRL,
    IDX_CMD,
    IDX_STATUS,
    IDX_EVENT,
    IDX_IRQ_MASK,
    IDX_COUNT,
    IDX_NONE
  } reg_index_e;

endpackage

`default_nettype wire
